/* dv/pwr_ack_model.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// power switch model
// echoes each switch enable after a random delay
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pwr_ack_model #(
  parameter int NUM_DOMAINS = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  pwr_pkg::pwr_out_t [NUM_DOMAINS-1:0] pwr_i,
  output logic [NUM_DOMAINS-1:0]              ack_no
);

  int unsigned delay [NUM_DOMAINS];

  // ack moves on the falling edge like every other DUT input
  always @(negedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ack_no <= '1;
      for (int i = 0; i < NUM_DOMAINS; i++) begin
        delay[i] <= 0;
      end
    end else begin
      for (int i = 0; i < NUM_DOMAINS; i++) begin
        if (ack_no[i] == pwr_i[i].pwrgate_en_n) begin
          delay[i] <= 0;
        end else if (delay[i] == 0) begin
          delay[i] <= $urandom_range(1, 8);
        end else if (delay[i] == 1) begin
          ack_no[i] <= pwr_i[i].pwrgate_en_n;
          delay[i]  <= 0;
        end else begin
          delay[i] <= delay[i] - 1;
        end
      end
    end
  end

endmodule

/* dv/pwr_tb_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// power controller testbench
// random commands checked against a per-domain model
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pwr_tb_top;

  localparam int NUM_DOMAINS    = 4;
  localparam int SETTLE_CYCLES  = 4;
  localparam int NUM_CMDS       = 150;
  localparam int TIMEOUT_CYCLES = 60 * NUM_CMDS + 100;
  // field masks in pwr_out_t bit order
  localparam logic [4:0] M_SW  = 5'b10000;
  localparam logic [4:0] M_ISO = 5'b01000;
  localparam logic [4:0] M_RST = 5'b00100;
  localparam logic [4:0] M_CLK = 5'b00010;
  localparam logic [4:0] M_RET = 5'b00001;

  logic                                clk = 1'b0;
  logic                                rst_n;
  logic                                dbg_rst_n;
  logic                                cmd_valid;
  pwr_pkg::pwr_cmd_t                   cmd;
  logic [NUM_DOMAINS-1:0]              ack_n;
  pwr_pkg::pwr_out_t [NUM_DOMAINS-1:0] pwr;
  logic [NUM_DOMAINS-1:0]              done;
  logic                                irq;

  pwr_pkg::pwr_out_t exp_out   [NUM_DOMAINS];
  pwr_pkg::pwr_out_t prev_out  [NUM_DOMAINS];
  logic              retained  [NUM_DOMAINS];
  logic              busy      [NUM_DOMAINS];
  int                start_cyc [NUM_DOMAINS];
  logic [4:0]        steps     [NUM_DOMAINS][5];
  int                n_steps   [NUM_DOMAINS];
  int                step_idx  [NUM_DOMAINS];
  logic              pend;
  logic [2:0]        clr_sr;
  logic              monitor_on;
  int                cyc;
  int                timeout_cnt = 0;
  string             test_name;

  always #4 clk = ~clk;

  pwr_ctrl_top #(
    .NUM_DOMAINS  (NUM_DOMAINS),
    .SETTLE_CYCLES(SETTLE_CYCLES)
  ) i_pwr_ctrl_top (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .dbg_rst_ni    (dbg_rst_n),
    .cmd_valid_i   (cmd_valid),
    .cmd_i         (cmd),
    .pwrgate_ack_ni(ack_n),
    .pwr_o         (pwr),
    .done_o        (done),
    .pwr_irq_o     (irq)
  );

  pwr_ack_model #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) i_ack_model (
    .clk_i  (clk),
    .rst_n_i(rst_n),
    .pwr_i  (pwr),
    .ack_no (ack_n)
  );

  task automatic abort_run(string why);
    $display("%s", why);
    $display("RESULT: FAIL");
    $fatal(1, "run aborted");
  endtask

  task automatic expect_equal(string what, int unsigned exp, int unsigned act);
    if (exp != act) begin
      $display("FAIL %s %s: expected %0h, actual %0h", test_name, what, exp, act);
      $display("RESULT: FAIL");
      $fatal(1, "value mismatch");
    end
  endtask

  always @(posedge clk) begin
    timeout_cnt++;
    if (timeout_cnt > TIMEOUT_CYCLES) begin
      abort_run($sformatf("timeout: run still going after %0d cycles", TIMEOUT_CYCLES));
    end
  end

  function automatic void add_step(int d, logic [4:0] m);
    steps[d][n_steps[d]] = m;
    n_steps[d]++;
  endfunction

  function automatic logic any_busy();
    logic b;
    b = 1'b0;
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      b |= busy[d];
    end
    return b;
  endfunction

  // a busy domain may be hit only while it surely has not finished
  function automatic logic cmd_is_safe(pwr_pkg::pwr_cmd_t c);
    int d;
    d = int'(c.domain);
    return !(d < NUM_DOMAINS && c.op <= pwr_pkg::op_ret_clr && busy[d] &&
             cyc - start_cyc[d] > 1);
  endfunction

  task automatic observe_cycle();
    logic [4:0] chg;
    clr_sr = {clr_sr[1:0], 1'b0};
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      if (monitor_on) begin
        chg = prev_out[d] ^ pwr[d];
        if (chg != '0 && step_idx[d] >= n_steps[d]) begin
          abort_run($sformatf("domain %0d outputs changed with no sequence running", d));
        end else if (chg != '0) begin
          expect_equal($sformatf("d%0d step %0d", d, step_idx[d]), steps[d][step_idx[d]], chg);
          // isolation lifts only behind a settled switch
          if (chg == M_ISO && pwr[d].isogate_en_n) begin
            expect_equal($sformatf("d%0d ack at iso release", d), 1, ack_n[d]);
          end
          step_idx[d]++;
        end
        prev_out[d] = pwr[d];
      end
      if (done[d] && !busy[d]) begin
        abort_run($sformatf("done pulse on domain %0d with no sequence running", d));
      end else if (done[d]) begin
        busy[d] = 1'b0;
        expect_equal($sformatf("d%0d final pwr_o", d), exp_out[d], pwr[d]);
        expect_equal($sformatf("d%0d steps seen", d), n_steps[d], step_idx[d]);
      end
    end
    if (|done) begin
      pend = 1'b1;
    end else if (clr_sr[2]) begin
      pend = 1'b0;
    end
    expect_equal("pwr_irq_o", pend, irq);
  endtask

  task automatic issue_cmd(pwr_pkg::pwr_cmd_t c);
    int d;
    d = int'(c.domain);
    cmd_valid = 1'b1;
    cmd       = c;
    if (d < NUM_DOMAINS && c.op == pwr_pkg::op_irq_clear) begin
      clr_sr[0] = 1'b1;
    end else if (d < NUM_DOMAINS && !busy[d]) begin
      n_steps[d]   = 0;
      step_idx[d]  = 0;
      start_cyc[d] = cyc;
      case (c.op)
        pwr_pkg::op_power_off: begin
          if (exp_out[d].pwrgate_en_n) begin
            busy[d] = 1'b1;
            add_step(d, M_CLK);
            add_step(d, M_RST);
            add_step(d, M_ISO);
            if (retained[d]) begin
              add_step(d, M_RET);
            end
            add_step(d, M_SW);
            exp_out[d] = '{1'b0, 1'b0, 1'b0, 1'b0, ~retained[d]};
          end
        end
        pwr_pkg::op_power_on: begin
          if (!exp_out[d].pwrgate_en_n) begin
            busy[d] = 1'b1;
            if (!exp_out[d].retentive_en_n) begin
              add_step(d, M_RET);
            end
            add_step(d, M_SW);
            add_step(d, M_ISO);
            add_step(d, M_RST);
            add_step(d, M_CLK);
            exp_out[d] = pwr_pkg::PWR_OUT_ON;
          end
        end
        pwr_pkg::op_ret_set, pwr_pkg::op_ret_clr: begin
          if (retained[d] != (c.op == pwr_pkg::op_ret_set)) begin
            busy[d]     = 1'b1;
            retained[d] = (c.op == pwr_pkg::op_ret_set);
          end
        end
        default: ;
      endcase
    end
  endtask

  task automatic step_cycle(logic issue, pwr_pkg::pwr_cmd_t c);
    @(negedge clk);
    cyc++;
    cmd_valid = 1'b0;
    observe_cycle();
    if (issue && cmd_is_safe(c)) begin
      issue_cmd(c);
    end
  endtask

  initial begin
    pwr_pkg::pwr_cmd_t c;
    pwr_pkg::pwr_out_t gated;
    int                gap;
    logic [2:0]        last_dom;
    void'($urandom(32'h28c));
    rst_n      = 1'b0;
    dbg_rst_n  = 1'b1;
    cmd_valid  = 1'b0;
    cmd        = '0;
    pend       = 1'b0;
    clr_sr     = '0;
    monitor_on = 1'b0;
    cyc        = 0;
    last_dom   = '0;
    test_name  = "reset";
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      exp_out[d]   = pwr_pkg::PWR_OUT_ON;
      prev_out[d]  = pwr_pkg::PWR_OUT_ON;
      retained[d]  = 1'b0;
      busy[d]      = 1'b0;
      start_cyc[d] = 0;
      n_steps[d]   = 0;
      step_idx[d]  = 0;
    end
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    step_cycle(1'b0, '0);
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      expect_equal($sformatf("d%0d pwr_o", d), pwr_pkg::PWR_OUT_ON, pwr[d]);
    end
    expect_equal("done_o", 0, done);
    monitor_on = 1'b1;

    test_name = "random";
    for (int n = 0; n < NUM_CMDS; n++) begin
      gap = $urandom_range(0, 3);
      repeat (gap) step_cycle(1'b0, '0);
      // back-to-back hits on the same domain reach a busy sequencer
      if (gap == 0 && $urandom_range(0, 1) == 1) begin
        c.domain = last_dom;
      end else if ($urandom_range(0, 9) == 0) begin
        c.domain = 3'($urandom_range(NUM_DOMAINS, 7));
      end else begin
        c.domain = 3'($urandom_range(0, NUM_DOMAINS - 1));
      end
      if ($urandom_range(0, 11) == 0) begin
        c.op = pwr_pkg::pwr_op_e'(3'($urandom_range(5, 7)));
      end else begin
        c.op = pwr_pkg::pwr_op_e'(3'($urandom_range(0, 4)));
      end
      last_dom = c.domain;
      step_cycle(1'b1, c);
    end
    while (any_busy()) begin
      step_cycle(1'b0, '0);
    end

    test_name  = "dbg_reset";
    monitor_on = 1'b0;
    dbg_rst_n  = 1'b0;
    step_cycle(1'b0, '0);
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      gated       = exp_out[d];
      gated.rst_n = 1'b0;
      expect_equal($sformatf("d%0d gated pwr_o", d), gated, pwr[d]);
    end
    dbg_rst_n = 1'b1;
    step_cycle(1'b0, '0);
    for (int d = 0; d < NUM_DOMAINS; d++) begin
      expect_equal($sformatf("d%0d released pwr_o", d), exp_out[d], pwr[d]);
    end
    monitor_on = 1'b1;
    repeat (4) step_cycle(1'b0, '0);

    $display("RESULT: PASS");
    $finish;
  end

endmodule

/* filelist.f */
src/pwr_pkg.sv
src/pwr_cmd_decode.sv
src/pwr_domain_seq.sv
src/pwr_event_unit.sv
src/pwr_ctrl_top.sv
dv/pwr_ack_model.sv
dv/pwr_tb_top.sv

/* src/pwr_cmd_decode.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// power command decoder
// validates strobed commands, routes them to a domain
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pwr_cmd_decode #(
  parameter int NUM_DOMAINS = 4
) (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   cmd_valid_i,
  input  pwr_pkg::pwr_cmd_t      cmd_i,
  output logic [NUM_DOMAINS-1:0] start_o,
  output pwr_pkg::pwr_cmd_t      start_cmd_o,
  output logic                   irq_clr_o
);

  logic                   dom_ok;
  logic                   seq_op;
  logic                   clr_op;
  logic [NUM_DOMAINS-1:0] start_d;

  assign dom_ok = (int'(cmd_i.domain) < NUM_DOMAINS);

  always_comb begin
    seq_op = 1'b0;
    clr_op = 1'b0;
    case (cmd_i.op)
      pwr_pkg::op_power_off,
      pwr_pkg::op_power_on,
      pwr_pkg::op_ret_set,
      pwr_pkg::op_ret_clr: seq_op = 1'b1;
      pwr_pkg::op_irq_clear: clr_op = 1'b1;
      default: ;
    endcase
  end

  // one-hot by domain index
  always_comb begin
    for (int i = 0; i < NUM_DOMAINS; i++) begin
      start_d[i] = cmd_valid_i && seq_op && dom_ok && (int'(cmd_i.domain) == i);
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      start_o   <= '0;
      irq_clr_o <= 1'b0;
    end else begin
      start_o   <= start_d;
      irq_clr_o <= cmd_valid_i && clr_op && dom_ok;
    end
  end

  // held until the next command
  always_ff @(posedge clk_i) begin
    if (cmd_valid_i) begin
      start_cmd_o <= cmd_i;
    end
  end

  a_start_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $onehot0(start_o));

endmodule

/* src/pwr_ctrl_top.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// power controller top
// decoder, per-domain sequencers and event unit
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pwr_ctrl_top #(
  parameter int NUM_DOMAINS   = 4,
  parameter int SETTLE_CYCLES = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                dbg_rst_ni,
  input  logic                                cmd_valid_i,
  input  pwr_pkg::pwr_cmd_t                   cmd_i,
  input  logic [NUM_DOMAINS-1:0]              pwrgate_ack_ni,
  output pwr_pkg::pwr_out_t [NUM_DOMAINS-1:0] pwr_o,
  output logic [NUM_DOMAINS-1:0]              done_o,
  output logic                                pwr_irq_o
);

  logic [NUM_DOMAINS-1:0]              start;
  pwr_pkg::pwr_cmd_t                   start_cmd;
  logic                                irq_clr;
  pwr_pkg::pwr_out_t [NUM_DOMAINS-1:0] seq_out;
  logic [NUM_DOMAINS-1:0]              seq_done;

  if (NUM_DOMAINS < 1 || NUM_DOMAINS > pwr_pkg::MAX_DOMAINS) begin : g_bad_cfg
    $error("NUM_DOMAINS out of range");
  end

  pwr_cmd_decode #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) i_cmd_decode (
    .clk_i,
    .rst_n_i,
    .cmd_valid_i,
    .cmd_i,
    .start_o    (start),
    .start_cmd_o(start_cmd),
    .irq_clr_o  (irq_clr)
  );

  // one sequencer per domain
  for (genvar i = 0; i < NUM_DOMAINS; i++) begin : g_seq
    pwr_domain_seq #(
      .SETTLE_CYCLES(SETTLE_CYCLES)
    ) i_domain_seq (
      .clk_i,
      .rst_n_i,
      .start_i       (start[i]),
      .op_i          (start_cmd.op),
      .pwrgate_ack_ni(pwrgate_ack_ni[i]),
      .pwr_o         (seq_out[i]),
      .done_o        (seq_done[i])
    );
  end

  pwr_event_unit #(
    .NUM_DOMAINS(NUM_DOMAINS)
  ) i_event_unit (
    .clk_i,
    .rst_n_i,
    .dbg_rst_ni,
    .seq_out_i (seq_out),
    .seq_done_i(seq_done),
    .irq_clr_i (irq_clr),
    .pwr_o,
    .done_o,
    .pwr_irq_o
  );

endmodule

/* src/pwr_domain_seq.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// power domain sequencer
// ordered power-off/on steps with switch ack wait
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pwr_domain_seq #(
  parameter int SETTLE_CYCLES = 4
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              start_i,
  input  pwr_pkg::pwr_op_e  op_i,
  input  logic              pwrgate_ack_ni,
  output pwr_pkg::pwr_out_t pwr_o,
  output logic              done_o
);

  localparam int CNT_W = $clog2(SETTLE_CYCLES + 2);

  typedef enum logic [3:0] {
    s_idle,
    s_off_clk,
    s_off_rst,
    s_off_iso,
    s_off_ret,
    s_off_sw,
    s_off_wait,
    s_on_ret,
    s_on_sw,
    s_on_wait,
    s_on_settle,
    s_on_iso,
    s_on_rst,
    s_on_clk,
    s_ret_done
  } state_e;

  state_e            state_q;
  pwr_pkg::pwr_out_t pwr_q;
  logic              retained_q;
  logic              done_q;
  logic [CNT_W-1:0]  cnt_q;
  logic              ack_match;
  logic              ret_req;

  // switch cell has caught up with the enable
  assign ack_match = (pwrgate_ack_ni == pwr_q.pwrgate_en_n);
  assign ret_req   = (op_i == pwr_pkg::op_ret_set);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q    <= s_idle;
      pwr_q      <= pwr_pkg::PWR_OUT_ON;
      retained_q <= 1'b0;
      done_q     <= 1'b0;
      cnt_q      <= '0;
    end else begin
      done_q <= 1'b0;
      case (state_q)
        s_idle: begin
          // requests for the current state are dropped
          if (start_i) begin
            case (op_i)
              pwr_pkg::op_power_off: begin
                if (pwr_q.pwrgate_en_n) begin
                  state_q <= s_off_clk;
                end
              end
              pwr_pkg::op_power_on: begin
                if (!pwr_q.pwrgate_en_n) begin
                  state_q <= s_on_ret;
                end
              end
              pwr_pkg::op_ret_set,
              pwr_pkg::op_ret_clr: begin
                if (retained_q != ret_req) begin
                  retained_q <= ret_req;
                  state_q    <= s_ret_done;
                end
              end
              default: ;
            endcase
          end
        end
        s_off_clk: begin
          pwr_q.clkgate_en_n <= 1'b0;
          state_q            <= s_off_rst;
        end
        s_off_rst: begin
          pwr_q.rst_n <= 1'b0;
          state_q     <= s_off_iso;
        end
        s_off_iso: begin
          pwr_q.isogate_en_n <= 1'b0;
          state_q            <= s_off_ret;
        end
        s_off_ret: begin
          pwr_q.retentive_en_n <= ~retained_q;
          state_q              <= s_off_sw;
        end
        s_off_sw: begin
          pwr_q.pwrgate_en_n <= 1'b0;
          state_q            <= s_off_wait;
        end
        s_off_wait: begin
          if (ack_match) begin
            done_q  <= 1'b1;
            state_q <= s_idle;
          end
        end
        s_on_ret: begin
          pwr_q.retentive_en_n <= 1'b1;
          state_q              <= s_on_sw;
        end
        s_on_sw: begin
          pwr_q.pwrgate_en_n <= 1'b1;
          state_q            <= s_on_wait;
        end
        s_on_wait: begin
          if (ack_match) begin
            cnt_q   <= CNT_W'(SETTLE_CYCLES);
            state_q <= s_on_settle;
          end
        end
        s_on_settle: begin
          if (cnt_q <= CNT_W'(1)) begin
            state_q <= s_on_iso;
          end else begin
            cnt_q <= cnt_q - CNT_W'(1);
          end
        end
        s_on_iso: begin
          pwr_q.isogate_en_n <= 1'b1;
          state_q            <= s_on_rst;
        end
        s_on_rst: begin
          pwr_q.rst_n <= 1'b1;
          state_q     <= s_on_clk;
        end
        s_on_clk: begin
          pwr_q.clkgate_en_n <= 1'b1;
          done_q             <= 1'b1;
          state_q            <= s_idle;
        end
        s_ret_done: begin
          done_q  <= 1'b1;
          state_q <= s_idle;
        end
        default: state_q <= s_idle;
      endcase
    end
  end

  assign pwr_o  = pwr_q;
  assign done_o = done_q;

  // switch may only be open behind isolation
  a_iso_when_off: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !pwr_q.pwrgate_en_n |-> !pwr_q.isogate_en_n);

  a_rst_when_clk_iso: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (pwr_q.clkgate_en_n && !pwr_q.isogate_en_n) |-> !pwr_q.rst_n);

endmodule

/* src/pwr_event_unit.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// power event unit
// done strobes, sticky irq, debug reset gating
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps

module pwr_event_unit #(
  parameter int NUM_DOMAINS = 4
) (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  input  logic                                dbg_rst_ni,
  input  pwr_pkg::pwr_out_t [NUM_DOMAINS-1:0] seq_out_i,
  input  logic [NUM_DOMAINS-1:0]              seq_done_i,
  input  logic                                irq_clr_i,
  output pwr_pkg::pwr_out_t [NUM_DOMAINS-1:0] pwr_o,
  output logic [NUM_DOMAINS-1:0]              done_o,
  output logic                                pwr_irq_o
);

  logic pend_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      done_o <= '0;
      pend_q <= 1'b0;
    end else begin
      done_o <= seq_done_i;
      // a new completion beats a clear in the same cycle
      if (|seq_done_i) begin
        pend_q <= 1'b1;
      end else if (irq_clr_i) begin
        pend_q <= 1'b0;
      end
    end
  end

  assign pwr_irq_o = pend_q;

  // debug module reset also holds every domain in reset
  always_comb begin
    for (int i = 0; i < NUM_DOMAINS; i++) begin
      pwr_o[i]       = seq_out_i[i];
      pwr_o[i].rst_n = seq_out_i[i].rst_n & dbg_rst_ni;
    end
  end

  a_irq_after_done: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    $rose(pwr_irq_o) |-> $past(|seq_done_i));

endmodule

/* src/pwr_pkg.sv */
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// power controller package
// command, opcode and per-domain control types
// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

package pwr_pkg;

  localparam int MAX_DOMAINS = 8;
  localparam int DOMAIN_W    = 3;

  // codes 5..7 are reserved
  typedef enum logic [2:0] {
    op_power_off = 3'd0,
    op_power_on  = 3'd1,
    op_ret_set   = 3'd2,
    op_ret_clr   = 3'd3,
    op_irq_clear = 3'd4
  } pwr_op_e;

  typedef struct packed {
    pwr_op_e             op;
    logic [DOMAIN_W-1:0] domain;
  } pwr_cmd_t;

  // all active low, one set per domain
  typedef struct packed {
    logic pwrgate_en_n;
    logic isogate_en_n;
    logic rst_n;
    logic clkgate_en_n;
    logic retentive_en_n;
  } pwr_out_t;

  // powered, running, not retentive
  localparam pwr_out_t PWR_OUT_ON = '{
    pwrgate_en_n:   1'b1,
    isogate_en_n:   1'b1,
    rst_n:          1'b1,
    clkgate_en_n:   1'b1,
    retentive_en_n: 1'b1
  };

endpackage
